//--- vlog.f
+incdir+.
ringPkg.sv
rcCtrlPkg.sv
reqChannel.sv
rspChannel.sv
f2cBuffer.sv
ventCounter.sv
rspArbiter.sv
ringCtrl.sv
tbRingCtrl.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/10ps
TOP      = tbRingCtrl
FILELIST = vlog.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, then search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tbModel.svh
// Testbench reference model: expected-value queues, LCG stimulus source and typed compare tasks
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // ============================================================
    // Model state
    // ============================================================
    logic [31:0] lcgState = 32'hd8896092;

    ringPkg::tRingPkt   expReqOutQ[$];  // ringReqOut, exactly 2 cycles behind the input
    ringPkg::tCoreReq   expF2cReqQ[$];
    ringPkg::tCoreRsp   expC2fRspQ[$];
    ringPkg::tRingPkt   expFwdQ[$];     // Forwarded response or free slot
    ringPkg::tRingPkt   expInjQ[$];     // Core answers in injection order
    ringPkg::tRequestor reqTagQ[$];     // Requestors of targeted RD/WR, send order
    ringPkg::tCoreReq   pendReqQ[$];    // Delivered RD/WR still waiting for an answer
    ringPkg::tRequestor pendTagQ[$];    // Their requestors

    int ringErrors  = 0;
    int coreErrors  = 0;
    int c2fErrors   = 0;
    int otherErrors = 0;

    // Plain 32-bit LCG, Numerical Recipes constants
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ============================================================
    // Compare tasks, payload only matters when valid is expected
    // ============================================================
    task automatic checkRingPkt(input string name, input ringPkg::tRingPkt got,
                                input ringPkg::tRingPkt exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            ringErrors++;
            $display("** Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic checkCoreReq(input string name, input ringPkg::tCoreReq got,
                                input ringPkg::tCoreReq exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            coreErrors++;
            $display("** Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic checkCoreRsp(input string name, input ringPkg::tCoreRsp got,
                                input ringPkg::tCoreRsp exp);
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            c2fErrors++;
            $display("** Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    // Anything that is not a value mismatch
    task automatic reportFailure(input string what);
        otherErrors++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

`endif

//--- tbRingCtrl.sv
// Ring controller testbench: random ring and core traffic checked against a queue model
`timescale 1ns/10ps

module tbRingCtrl;

    localparam ringPkg::tCoreId CORE_ID        = 8'h05;
    localparam int              F2C_DEPTH      = 4;
    localparam int              VENT_LIMIT     = 3;
    localparam int              NUM_CYCLES     = 2000; // Random stimulus cycles
    localparam int              TIMEOUT_CYCLES = NUM_CYCLES + F2C_DEPTH * 8 + 50;

    logic             QClk;
    logic             rstN;
    ringPkg::tRingPkt ringReqIn;
    ringPkg::tRingPkt ringRspIn;
    ringPkg::tRingPkt ringReqOut;
    ringPkg::tRingPkt ringRspOut;
    ringPkg::tCoreReq f2cReq;
    ringPkg::tCoreReq f2cRsp;
    ringPkg::tCoreRsp c2fRsp;

    int cycleCount = 0;
    int inFlight   = 0; // Targeted RD/WR sent, answer not yet back on the ring
    int ventRun    = 0; // Injected packets since the last free slot
    int coreDelay  = 0; // Core idle cycles before its next answer

    `include "tbModel.svh"

    ringCtrl #(
        .CORE_ID    (CORE_ID),
        .F2C_DEPTH  (F2C_DEPTH),
        .VENT_LIMIT (VENT_LIMIT)
    ) i_ringCtrl (
        .QClk       (QClk),
        .rstN       (rstN),
        .ringReqIn  (ringReqIn),
        .ringRspIn  (ringRspIn),
        .ringReqOut (ringReqOut),
        .ringRspOut (ringRspOut),
        .f2cReq     (f2cReq),
        .f2cRsp     (f2cRsp),
        .c2fRsp     (c2fRsp)
    );

    initial begin
        QClk = 1'b0;
        forever #10 QClk = ~QClk; // 20 ns period
    end

    // Hard stop if answers never come back
    always @(posedge QClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles with core answers still missing", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ============================================================
    // Output checks, done at the falling edge before new inputs
    // ============================================================
    task automatic sampleOutputs();
        ringPkg::tRingPkt fwd;
        fwd = expFwdQ.pop_front();
        checkRingPkt("ringReqOut", ringReqOut, expReqOutQ.pop_front());
        checkCoreReq("f2cReq", f2cReq, expF2cReqQ.pop_front());
        checkCoreRsp("c2fRsp", c2fRsp, expC2fRspQ.pop_front());
        if (fwd.valid) begin
            checkRingPkt("ringRspOut", ringRspOut, fwd); // Forwarding owns this slot
        end else if (ringRspOut.valid) begin
            if (!ringRspOut.data[31]) begin
                reportFailure("ringRspOut carries a packet that is neither forwarded nor injected");
            end else if (expInjQ.size() == 0) begin
                reportFailure("ringRspOut injected a response the core never gave");
            end else begin
                checkRingPkt("ringRspOut", ringRspOut, expInjQ.pop_front());
                inFlight--;
            end
        end
        // Bubble rule, forwarded slots hold the run
        if (ringRspOut.valid && ringRspOut.data[31]) begin
            ventRun++;
            if (ventRun > VENT_LIMIT) begin
                reportFailure("too many injected responses in a row without a free slot");
            end
        end else if (!ringRspOut.valid) begin
            ventRun = 0;
        end
        // Core takes delivered RD/WR, broadcasts need no answer
        if (f2cReq.valid && (f2cReq.opcode == ringPkg::RD || f2cReq.opcode == ringPkg::WR)) begin
            if (reqTagQ.size() == 0) begin
                reportFailure("core received a RD/WR that was never sent to it");
            end else begin
                pendReqQ.push_back(f2cReq);
                pendTagQ.push_back(reqTagQ.pop_front());
            end
        end
    endtask

    // In-order core answers after a random pause
    task automatic coreAnswer();
        logic [31:0]      r;
        ringPkg::tCoreReq req;
        ringPkg::tRingPkt inj;
        f2cRsp = '0;
        if (coreDelay > 0) begin
            coreDelay--;
        end else if (pendReqQ.size() != 0) begin
            req = pendReqQ.pop_front();
            r = nextRand();
            f2cRsp.valid   = 1'b1;
            f2cRsp.opcode  = ringPkg::RD_RSP;
            f2cRsp.address = req.address;
            f2cRsp.data    = {1'b1, r[30:0]}; // Bit 31 marks core answers
            inj.valid     = 1'b1;
            inj.requestor = pendTagQ.pop_front();
            inj.opcode    = ringPkg::RD_RSP;
            inj.address   = req.address;
            inj.data      = f2cRsp.data;
            expInjQ.push_back(inj);
            r = nextRand();
            coreDelay = int'(r[31:30]);
        end
    endtask

    // ============================================================
    // Ring stimulus and its expected results
    // ============================================================
    task automatic driveStimulus(input bit active);
        logic [31:0]      r;
        ringPkg::tRingPkt req;
        ringPkg::tRingPkt rsp;
        ringPkg::tRingPkt expReq;
        ringPkg::tRingPkt expFwd;
        ringPkg::tCoreReq expF2c;
        ringPkg::tCoreRsp expC2f;
        logic             match;
        logic             rdWr;
        logic             isLocal;
        req = '0;
        rsp = '0;
        if (active) begin
            r = nextRand();
            req.valid     = (r[31:30] != 2'b00);  // Busy three cycles in four
            req.opcode    = ringPkg::tOpcode'(r[29:28]);
            req.requestor = r[27:18];
            req.address   = nextRand();
            r = nextRand();
            req.data      = {1'b0, r[30:0]};
            req.address[31:24] = ((r[31:16] % 16'd3) == 16'd0) ? CORE_ID
                                                                 : CORE_ID ^ (r[7:0] | 8'h01);
            r = nextRand();
            rsp.valid     = (r[31:30] != 2'b00);
            rsp.opcode    = ringPkg::tOpcode'(r[29:28]);
            rsp.address   = nextRand();
            r = nextRand();
            rsp.data      = {1'b0, r[30:0]};
            rsp.requestor = {(((r[31:16] % 16'd3) == 16'd0) ? CORE_ID
                                                             : CORE_ID ^ (r[7:0] | 8'h01)),
                             r[9:8]};
        end
        match = (req.address[31:24] == CORE_ID);
        rdWr  = (req.opcode == ringPkg::RD) || (req.opcode == ringPkg::WR);
        if (req.valid && match && rdWr && inFlight >= F2C_DEPTH) begin
            req.address[31:24] = CORE_ID ^ 8'h80; // Core full, send it past
            match = 1'b0;
        end
        if (req.valid && match && rdWr) begin
            reqTagQ.push_back(req.requestor);
            inFlight++;
        end
        expReq = req;
        expReq.valid   = req.valid && !(match && rdWr);
        expF2c.valid   = req.valid && ((match && rdWr) || req.opcode == ringPkg::WR_BCAST);
        expF2c.opcode  = req.opcode;
        expF2c.address = req.address;
        expF2c.data    = req.data;
        isLocal = (rsp.requestor[9:2] == CORE_ID);
        expC2f.valid    = rsp.valid && isLocal;
        expC2f.opcode   = rsp.opcode;
        expC2f.data     = rsp.data;
        expC2f.threadId = rsp.requestor[1:0];
        expFwd = rsp;
        expFwd.valid = rsp.valid && !isLocal;
        expReqOutQ.push_back(expReq);
        expF2cReqQ.push_back(expF2c);
        expC2fRspQ.push_back(expC2f);
        expFwdQ.push_back(expFwd);
        ringReqIn = req;
        ringRspIn = rsp;
    endtask

    task automatic runCycle(input bit active);
        @(negedge QClk);
        sampleOutputs();
        coreAnswer();
        driveStimulus(active);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        rstN      = 1'b0;
        ringReqIn = '0;
        ringRspIn = '0;
        f2cRsp    = '0;
        repeat (3) @(posedge QClk);
        @(negedge QClk);
        rstN = 1'b1;
        repeat (2) begin // Empty slots from the reset cycles
            expReqOutQ.push_back('0);
            expF2cReqQ.push_back('0);
            expC2fRspQ.push_back('0);
            expFwdQ.push_back('0);
        end
        repeat (NUM_CYCLES) runCycle(1'b1);
        repeat (3) runCycle(1'b0); // Flush both pipelines
        while (expInjQ.size() != 0 || pendReqQ.size() != 0) begin
            runCycle(1'b0);
        end
        if (reqTagQ.size() != 0) begin
            reportFailure("targeted RD/WR requests never reached the core");
        end
        $display("Errors: ring %0d, f2cReq %0d, c2fRsp %0d, other %0d",
                 ringErrors, coreErrors, c2fErrors, otherErrors);
        if (ringErrors + coreErrors + c2fErrors + otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- ringCtrl.sv
// Ring controller top: attaches one core to the request and response rings
`timescale 1ns/10ps

module ringCtrl #(
    parameter ringPkg::tCoreId CORE_ID    = 8'h05,
    parameter int              F2C_DEPTH  = 4,     // Max outstanding core answers
    parameter int              VENT_LIMIT = 3      // Injections before a bubble
) (
    input  logic             QClk,
    input  logic             rstN,
    input  ringPkg::tRingPkt ringReqIn,   // Q500
    input  ringPkg::tRingPkt ringRspIn,   // Q500
    output ringPkg::tRingPkt ringReqOut,  // Q502
    output ringPkg::tRingPkt ringRspOut,  // Q502
    output ringPkg::tCoreReq f2cReq,      // Q502
    input  ringPkg::tCoreReq f2cRsp,      // Core answer
    output ringPkg::tCoreRsp c2fRsp       // Q502
);

    logic               tagPush;
    ringPkg::tRequestor tagRequestor;
    ringPkg::tRingPkt   injPkt;
    logic               mustFwd;
    logic               needVent;
    rcCtrlPkg::tWinner  winner;

    // ============================================================
    // Request path
    // ============================================================
    reqChannel #(
        .CORE_ID (CORE_ID)
    ) reqChannelInst (
        .QClk         (QClk),
        .rstN         (rstN),
        .ringReqIn    (ringReqIn),
        .ringReqOut   (ringReqOut),
        .f2cReq       (f2cReq),
        .tagPush      (tagPush),      // Into the tag queue
        .tagRequestor (tagRequestor)
    );

    // Core answers wait here with their tags
    f2cBuffer #(
        .F2C_DEPTH (F2C_DEPTH)
    ) f2cBufferInst (
        .QClk         (QClk),
        .rstN         (rstN),
        .tagPush      (tagPush),
        .tagRequestor (tagRequestor),
        .f2cRsp       (f2cRsp),
        .winner       (winner),       // Pops on F2C_RESPONSE
        .injPkt       (injPkt)
    );

    // ============================================================
    // Response path and arbitration
    // ============================================================
    rspChannel #(
        .CORE_ID (CORE_ID)
    ) rspChannelInst (
        .QClk       (QClk),
        .rstN       (rstN),
        .ringRspIn  (ringRspIn),
        .injPkt     (injPkt),
        .winner     (winner),
        .mustFwd    (mustFwd),
        .ringRspOut (ringRspOut),
        .c2fRsp     (c2fRsp)
    );

    ventCounter #(
        .VENT_LIMIT (VENT_LIMIT)
    ) ventCounterInst (
        .QClk     (QClk),
        .rstN     (rstN),
        .winner   (winner),
        .needVent (needVent)
    );

    // Combinational, same cycle as the Q501 stage
    rspArbiter rspArbiterInst (
        .mustFwd  (mustFwd),
        .needVent (needVent),
        .injPkt   (injPkt),
        .winner   (winner)
    );

endmodule

//--- rspArbiter.sv
// Response arbiter: picks the response ring owner for this cycle by fixed priority
`timescale 1ns/10ps

module rspArbiter (
    input  logic              mustFwd,  // Ring traffic passing through
    input  logic              needVent,
    input  ringPkg::tRingPkt  injPkt,   // Valid means buffer not empty
    output rcCtrlPkg::tWinner winner
);

    // Forward, then vent, then inject, else idle
    always_comb begin
        if (mustFwd) begin
            winner = rcCtrlPkg::RING_INPUT;   // Never drop ring traffic
        end else if (needVent) begin
            winner = rcCtrlPkg::BUBBLE_OUT;
        end else if (injPkt.valid) begin
            winner = rcCtrlPkg::F2C_RESPONSE;
        end else begin
            winner = rcCtrlPkg::BUBBLE_OUT;   // Nothing to send
        end
    end

endmodule

//--- ventCounter.sv
// Ventilation counter: counts back-to-back injections and asks for a bubble at the limit
`timescale 1ns/10ps

module ventCounter #(
    parameter int VENT_LIMIT = 3
) (
    input  logic              QClk,
    input  logic              rstN,
    input  rcCtrlPkg::tWinner winner,
    output logic              needVent  // Force the next free slot empty
);

    rcCtrlPkg::tVentCnt ventCnt;

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            ventCnt <= '0;
        end else begin
            case (winner)
                rcCtrlPkg::F2C_RESPONSE: ventCnt <= ventCnt + 1'b1;
                rcCtrlPkg::BUBBLE_OUT:   ventCnt <= '0;     // Ring got its gap
                default:                 ventCnt <= ventCnt; // Forwarding holds
            endcase
        end
    end

    assign needVent = (ventCnt == rcCtrlPkg::tVentCnt'(VENT_LIMIT));

endmodule

//--- f2cBuffer.sv
// F2C buffer: queues requestor tags and in-order core answers until injection is granted
`timescale 1ns/10ps

module f2cBuffer #(
    parameter int F2C_DEPTH = 4
) (
    input  logic               QClk,
    input  logic               rstN,
    input  logic               tagPush,
    input  ringPkg::tRequestor tagRequestor,
    input  ringPkg::tCoreReq   f2cRsp,  // Core answer, Q500
    input  rcCtrlPkg::tWinner  winner,
    output ringPkg::tRingPkt   injPkt   // Head, valid when non-empty
);

    localparam int PTR_W = (F2C_DEPTH > 1) ? $clog2(F2C_DEPTH) : 1;
    localparam int CNT_W = $clog2(F2C_DEPTH + 1);

    typedef logic [PTR_W-1:0] tPtr;
    typedef logic [CNT_W-1:0] tCnt;

    ringPkg::tRequestor tagMem [F2C_DEPTH]; // Who asked, in request order
    ringPkg::tCoreReq   rspMem [F2C_DEPTH]; // Core answers, same order
    tPtr                tagWrPtr;
    tPtr                rspWrPtr;
    tPtr                rdPtr;              // Both queues pop together
    tCnt                rspCnt;             // Answers waiting
    logic               pop;

    // Wrap at F2C_DEPTH, which need not be a power of two
    function automatic tPtr nextPtr(input tPtr ptr);
        nextPtr = (ptr == tPtr'(F2C_DEPTH - 1)) ? '0 : tPtr'(ptr + 1'b1);
    endfunction

    assign pop = (winner == rcCtrlPkg::F2C_RESPONSE);

    // ============================================================
    // Storage
    // ============================================================
    always_ff @(posedge QClk) begin
        if (tagPush) begin
            tagMem[tagWrPtr] <= tagRequestor;
        end
        if (f2cRsp.valid) begin
            rspMem[rspWrPtr] <= f2cRsp;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            tagWrPtr <= '0;
            rspWrPtr <= '0;
            rdPtr    <= '0;
            rspCnt   <= '0;
        end else begin
            if (tagPush) tagWrPtr <= nextPtr(tagWrPtr);
            if (f2cRsp.valid) rspWrPtr <= nextPtr(rspWrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            case ({f2cRsp.valid, pop})
                2'b10:   rspCnt <= rspCnt + 1'b1;
                2'b01:   rspCnt <= rspCnt - 1'b1;
                default: rspCnt <= rspCnt; // Idle or push with pop
            endcase
        end
    end

    // Head answer joined with its tag
    always_comb begin
        injPkt.valid     = (rspCnt != '0);
        injPkt.requestor = tagMem[rdPtr];
        injPkt.opcode    = rspMem[rdPtr].opcode;
        injPkt.address   = rspMem[rdPtr].address;
        injPkt.data      = rspMem[rdPtr].data;
    end

endmodule

//--- rspChannel.sv
// Response channel: registers ring responses, hands local ones to the core, muxes the ring output
`timescale 1ns/10ps

module rspChannel #(
    parameter ringPkg::tCoreId CORE_ID = 8'h05
) (
    input  logic              QClk,
    input  logic              rstN,
    input  ringPkg::tRingPkt  ringRspIn,  // Q500
    input  ringPkg::tRingPkt  injPkt,     // F2C buffer head
    input  rcCtrlPkg::tWinner winner,     // Q501 select
    output logic              mustFwd,    // Q501
    output ringPkg::tRingPkt  ringRspOut, // Q502
    output ringPkg::tCoreRsp  c2fRsp      // Q502
);

    ringPkg::tRingPkt rspQ501;
    ringPkg::tRingPkt outQ501; // Mux result before the output flop
    logic             idMatch;

    // ============================================================
    // Ring input stage
    // ============================================================
    always_ff @(posedge QClk) begin
        rspQ501 <= ringRspIn;
        if (!rstN) begin
            rspQ501.valid <= 1'b0;
        end
    end

    // Requestor core field, bits 9:2
    assign idMatch = (rspQ501.requestor[9:2] == CORE_ID);

    // Not ours, so it owns the ring output this cycle
    assign mustFwd = rspQ501.valid && !idMatch;

    // ============================================================
    // Output mux
    // ============================================================
    always_comb begin
        case (winner)
            rcCtrlPkg::RING_INPUT: begin
                outQ501 = rspQ501;      // Forward as received
            end
            rcCtrlPkg::F2C_RESPONSE: begin
                outQ501 = injPkt;       // Core answer with its tag
            end
            default: begin
                outQ501 = '0;           // Bubble, valid low
            end
        endcase
    end

    // Ring output and core delivery flops
    always_ff @(posedge QClk) begin
        ringRspOut      <= outQ501;
        c2fRsp.valid    <= rspQ501.valid && idMatch;
        c2fRsp.opcode   <= rspQ501.opcode;
        c2fRsp.data     <= rspQ501.data;
        c2fRsp.threadId <= rspQ501.requestor[1:0]; // Thread that asked
        if (!rstN) begin
            ringRspOut.valid <= 1'b0;
            c2fRsp.valid     <= 1'b0;
        end
    end

endmodule

//--- reqChannel.sv
// Request channel that delivers local RD/WR and broadcasts to the core and forwards the rest
`timescale 1ns/10ps

module reqChannel #(
    parameter ringPkg::tCoreId CORE_ID = 8'h05
) (
    input  logic               QClk,
    input  logic               rstN,
    input  ringPkg::tRingPkt   ringReqIn,    // Q500
    output ringPkg::tRingPkt   ringReqOut,   // Q502
    output ringPkg::tCoreReq   f2cReq,       // Q502
    output logic               tagPush,      // Q501 strobe per delivered RD/WR
    output ringPkg::tRequestor tagRequestor  // Q501
);

    ringPkg::tRingPkt reqQ501;
    logic             idMatch;   // Address top byte is ours
    logic             isRdWr;
    logic             isBcast;
    logic             deliver;   // Goes to the core
    logic             forward;   // Stays on the ring

    // ============================================================
    // Ring input stage
    // ============================================================
    always_ff @(posedge QClk) begin
        reqQ501 <= ringReqIn;
        if (!rstN) begin
            reqQ501.valid <= 1'b0; // Empty slot after reset
        end
    end

    // Classify by address and opcode
    always_comb begin
        idMatch = (reqQ501.address[31:24] == CORE_ID);
        isRdWr  = (reqQ501.opcode == ringPkg::RD) || (reqQ501.opcode == ringPkg::WR);
        isBcast = (reqQ501.opcode == ringPkg::WR_BCAST);
        deliver = reqQ501.valid && ((idMatch && isRdWr) || isBcast);
        forward = reqQ501.valid && !(idMatch && isRdWr); // Broadcast keeps travelling
    end

    // Only RD/WR get an answer and leave a tag
    assign tagPush      = reqQ501.valid && idMatch && isRdWr;
    assign tagRequestor = reqQ501.requestor;

    // ============================================================
    // Ring and core output stage
    // ============================================================
    always_ff @(posedge QClk) begin
        ringReqOut       <= reqQ501;        // Forwarded unchanged
        ringReqOut.valid <= forward;
        f2cReq.valid     <= deliver;
        f2cReq.opcode    <= reqQ501.opcode;
        f2cReq.address   <= reqQ501.address;
        f2cReq.data      <= reqQ501.data;
        if (!rstN) begin
            ringReqOut.valid <= 1'b0;
            f2cReq.valid     <= 1'b0;
        end
    end

endmodule

//--- rcCtrlPkg.sv
// Ring controller control types: response arbiter winner and ventilation count
package rcCtrlPkg;

    // ============================================================
    // Response ring arbitration
    // ============================================================
    // Who owns the response ring output in a given cycle
    typedef enum logic [1:0] {
        BUBBLE_OUT   = 2'b00, // Empty slot
        RING_INPUT   = 2'b01, // Forward the incoming ring response
        F2C_RESPONSE = 2'b10  // Inject the core's answer
    } tWinner;

    // Consecutive injected responses since the last bubble
    typedef logic [1:0] tVentCnt;

endpackage

//--- ringPkg.sv
// Ring packet formats: opcode, ID, address, data and the packet structs on ring and core sides
package ringPkg;

    // ============================================================
    // Field types
    // ============================================================
    typedef enum logic [1:0] {
        RD       = 2'b00, // Read request
        RD_RSP   = 2'b01, // Read response
        WR       = 2'b10, // Write request
        WR_BCAST = 2'b11  // Write to every core on the ring
    } tOpcode;

    typedef logic [7:0]  tCoreId;    // One per core on the ring
    typedef logic [1:0]  tThreadId;  // Thread inside a core
    typedef logic [9:0]  tRequestor; // {core ID, thread ID}
    typedef logic [31:0] tAddress;   // Top byte selects the target core
    typedef logic [31:0] tData;

    // ============================================================
    // Packet structs
    // ============================================================
    // Ring packet, both channels, 77 bits
    typedef struct packed {
        logic      valid;     // Single-cycle strobe
        tRequestor requestor; // Originating core and thread
        tOpcode    opcode;
        tAddress   address;
        tData      data;
    } tRingPkt;

    // Request toward the core, also the core's answer, 67 bits
    typedef struct packed {
        logic    valid;
        tOpcode  opcode;
        tAddress address;
        tData    data;
    } tCoreReq;

    // Response handed to a core thread, 37 bits
    typedef struct packed {
        logic     valid;
        tOpcode   opcode;
        tData     data;
        tThreadId threadId; // Thread that issued the request
    } tCoreRsp;

endpackage
